//--- common/sw_pkg.sv
//////////////////////////////
// shared widths, register map and mode codes.
// imported by the rtl and the checker.
//////////////////////////////
package sw_pkg;

  // switch word and spi frame sizes.
  localparam int num_bits   = 24;  // analog switch word.
  localparam int addr_bits  = 7;   // address field, read flag sits above it.
  localparam int frame_bits = 32;  // 8 bit address byte + 24 data bits.
  localparam int mode_bits  = 2;

  // register map.
  localparam logic [addr_bits-1:0] addr_mode    = 7'd0;  // read / write.
  localparam logic [addr_bits-1:0] addr_direct  = 7'd1;  // read / write.
  localparam logic [addr_bits-1:0] addr_direct2 = 7'd2;  // read / write.
  localparam logic [addr_bits-1:0] addr_id      = 7'd3;  // read only.

  // output mode codes.
  // code 3 is not defined and drives the switches off.
  localparam logic [mode_bits-1:0] mode_off       = 2'd0;
  localparam logic [mode_bits-1:0] mode_direct    = 2'd1;  // word from direct reg.
  localparam logic [mode_bits-1:0] mode_alternate = 2'd2;  // swap direct / direct2.

  // identity word, lets the host check the link.
  localparam logic [num_bits-1:0] id_value = 24'hA5_C3_01;

endpackage

//--- spi/spi_slave.sv
//////////////////////////////
// spi slave oversampled on clk. mode 0, msb first,
// 8 bit address byte (bit 7 = read) then 24 data bits.
//////////////////////////////
`timescale 1ns/1ps

module spi_slave
  import sw_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 spi_cs_n,
  input  logic                 spi_sck,
  input  logic                 spi_mosi,
  input  logic [num_bits-1:0]  rd_data,     // from reg bank, valid with addr_valid.
  output logic                 spi_miso,
  output logic                 addr_valid,  // one cycle, after 8th bit.
  output logic                 is_read,
  output logic [addr_bits-1:0] addr,
  output logic                 wr_strobe,   // one cycle, after cs rise.
  output logic [num_bits-1:0]  wr_data
);

  localparam int cnt_bits = $clog2(frame_bits) + 2;  // headroom for long frames.
  localparam logic [cnt_bits-1:0] cnt_max   = '1;
  localparam logic [cnt_bits-1:0] cnt_addr  = cnt_bits'(addr_bits);   // bits before last addr bit.
  localparam logic [cnt_bits-1:0] cnt_frame = cnt_bits'(frame_bits);

  logic [1:0]            cs_sync;    // [0] meta, [1] usable.
  logic [1:0]            sck_sync;
  logic [1:0]            mosi_sync;
  logic                  cs_prev;
  logic                  sck_prev;
  logic                  cs_active;
  logic                  cs_rise;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  addr_done;
  logic                  tx_shift_en;
  logic                  addr_ok;
  logic [cnt_bits-1:0]   bit_cnt;
  logic [num_bits-1:0]   shift_in;   // last 24 bits received.
  logic [num_bits-1:0]   tx_shift;

  // pin synchronizers. idle levels at reset, so no false edges.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cs_sync  <= 2'b11;
      sck_sync <= 2'b00;
      cs_prev  <= 1'b1;
      sck_prev <= 1'b0;
    end
    else
    begin
      cs_sync  <= {cs_sync[0], spi_cs_n};
      sck_sync <= {sck_sync[0], spi_sck};
      cs_prev  <= cs_sync[1];
      sck_prev <= sck_sync[1];
    end
  end

  always_ff @(posedge clk)
  begin
    mosi_sync <= {mosi_sync[0], spi_mosi};  // same two stages as sck.
  end

  assign cs_active   = ~cs_sync[1];
  assign cs_rise     = cs_sync[1] & ~cs_prev;                 // end of frame.
  assign sck_rise    = cs_active & sck_sync[1] & ~sck_prev;   // sample mosi.
  assign sck_fall    = cs_active & ~sck_sync[1] & sck_prev;   // launch miso.
  assign addr_done   = sck_rise && (bit_cnt == cnt_addr);     // 8th bit arriving.
  assign tx_shift_en = sck_fall && (bit_cnt > cnt_addr);

  // only mode, direct and direct2 take writes.
  assign addr_ok = (addr == addr_mode) || (addr == addr_direct) || (addr == addr_direct2);

  // bit count and strobes.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt    <= '0;
      addr_valid <= 1'b0;
      wr_strobe  <= 1'b0;
    end
    else
    begin
      if (!cs_active)
        bit_cnt <= '0;  // cleared between frames.
      else if (sck_rise && bit_cnt != cnt_max)
        bit_cnt <= bit_cnt + 1'b1;  // saturates on runaway frames.
      addr_valid <= addr_done;
      // exact length, write frame, writable address.
      wr_strobe <= cs_rise && (bit_cnt == cnt_frame) && !is_read && addr_ok;
    end
  end

  // receive path.
  always_ff @(posedge clk)
  begin
    if (sck_rise)
      shift_in <= {shift_in[num_bits-2:0], mosi_sync[1]};
    if (addr_done)
    begin
      is_read <= shift_in[addr_bits-1];                     // first bit in.
      addr    <= {shift_in[addr_bits-2:0], mosi_sync[1]};
    end
    if (cs_rise)
      wr_data <= shift_in;  // last 24 bits of the frame.
  end

  // transmit path. readback word loaded with addr_valid.
  always_ff @(posedge clk)
  begin
    if (addr_valid)
      tx_shift <= rd_data;
    else if (tx_shift_en)
      tx_shift <= {tx_shift[num_bits-2:0], 1'b0};
  end

  always_ff @(posedge clk)
  begin
    if (reset || !cs_active)
      spi_miso <= 1'b0;  // low when not selected.
    else if (tx_shift_en)
      spi_miso <= tx_shift[num_bits-1];  // msb first.
  end

endmodule

//--- spi/spi_reg_bank.sv
//////////////////////////////
// host registers behind the spi slave.
// mode, direct, direct2 writable, id read only.
//////////////////////////////
`timescale 1ns/1ps

module spi_reg_bank
  import sw_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 addr_valid,   // read address strobe.
  input  logic                 is_read,
  input  logic [addr_bits-1:0] addr,
  input  logic                 wr_strobe,    // one cycle write.
  input  logic [num_bits-1:0]  wr_data,
  output logic [num_bits-1:0]  rd_data,      // combinational readback.
  output logic [mode_bits-1:0] reg_mode,
  output logic [num_bits-1:0]  reg_direct,
  output logic [num_bits-1:0]  reg_direct2
);

  logic rd_en;

  // write decode.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reg_mode    <= mode_off;  // switches off after reset.
      reg_direct  <= '0;
      reg_direct2 <= '0;
    end
    else if (wr_strobe)
    begin
      case (addr)
        addr_mode:    reg_mode    <= wr_data[mode_bits-1:0];  // upper bits dropped.
        addr_direct:  reg_direct  <= wr_data;
        addr_direct2: reg_direct2 <= wr_data;
        default:      ;  // id and unused addresses ignore writes.
      endcase
    end
  end

  // readback mux. write frames shift back zeros.
  assign rd_en = addr_valid & is_read;

  always_comb
  begin
    rd_data = '0;
    if (rd_en)
    begin
      case (addr)
        addr_mode:    rd_data = {{(num_bits - mode_bits){1'b0}}, reg_mode};
        addr_direct:  rd_data = reg_direct;
        addr_direct2: rd_data = reg_direct2;
        addr_id:      rd_data = id_value;
        default:      rd_data = '0;  // unknown address.
      endcase
    end
  end

endmodule

//--- hw/pattern_alternate.sv
//////////////////////////////
// slow alternating pattern, swaps between two words
// every half_period + 1 clocks while enabled.
//////////////////////////////
`timescale 1ns/1ps

module pattern_alternate
  import sw_pkg::*;
#(
  parameter int half_period = 50  // cycles, board uses clk freq / 10.
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic [num_bits-1:0] reg_direct,
  input  logic [num_bits-1:0] reg_direct2,
  output logic [num_bits-1:0] pat_out
);

  localparam int cnt_bits = $clog2(half_period + 1);
  localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(half_period);

  logic [cnt_bits-1:0] counter;
  logic                state;  // 0 -> next load is direct.

  always_ff @(posedge clk)
  begin
    if (reset || !enable)
    begin
      // held at zero, so each enable starts a fresh period.
      counter <= '0;
      state   <= 1'b0;
      pat_out <= '0;
    end
    else if (counter == cnt_last)
    begin
      counter <= '0;
      state   <= ~state;
      if (state)
        pat_out <= reg_direct2;
      else
        pat_out <= reg_direct;  // first swap after enable.
    end
    else
    begin
      counter <= counter + 1'b1;
    end
  end

endmodule

//--- hw/switch_output.sv
//////////////////////////////
// registered switch word, chosen by the mode register.
//////////////////////////////
`timescale 1ns/1ps

module switch_output
  import sw_pkg::*;
#(
  parameter int half_period = 50
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [mode_bits-1:0] reg_mode,
  input  logic [num_bits-1:0]  reg_direct,
  input  logic [num_bits-1:0]  reg_direct2,
  output logic [num_bits-1:0]  sw_out       // drives the analog switches.
);

  logic [mode_bits-1:0] sel_q;       // decoded mode, invalid folded to off.
  logic                 alt_enable;
  logic [num_bits-1:0]  pat_out;

  // mode decode, one register stage.
  always_ff @(posedge clk)
  begin
    if (reset)
      sel_q <= mode_off;
    else
    begin
      case (reg_mode)
        mode_direct,
        mode_alternate: sel_q <= reg_mode;
        default:        sel_q <= mode_off;  // off and code 3.
      endcase
    end
  end

  // generator restarts the cycle after the mode change.
  assign alt_enable = (sel_q == mode_alternate);

  pattern_alternate #(
    .half_period (half_period)
  ) u_alternate (
    .clk         (clk),
    .reset       (reset),
    .enable      (alt_enable),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2),
    .pat_out     (pat_out)
  );

  // output register.
  always_ff @(posedge clk)
  begin
    if (reset)
      sw_out <= '0;
    else
    begin
      case (sel_q)
        mode_direct:    sw_out <= reg_direct;
        mode_alternate: sw_out <= pat_out;
        default:        sw_out <= '0;  // all switches open.
      endcase
    end
  end

endmodule

//--- hw/sw_ctrl_top.sv
//////////////////////////////
// switch pattern controller top. spi host in,
// switch word out, one clock domain.
//////////////////////////////
`timescale 1ns/1ps

module sw_ctrl_top
  import sw_pkg::*;
#(
  parameter int half_period = 10_000_000  // 100 mhz clk / 10.
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                spi_cs_n,
  input  logic                spi_sck,
  input  logic                spi_mosi,
  output logic                spi_miso,
  output logic [num_bits-1:0] sw_out
);

  // slave to bank.
  logic                 addr_valid;
  logic                 is_read;
  logic [addr_bits-1:0] addr;
  logic                 wr_strobe;
  logic [num_bits-1:0]  wr_data;
  logic [num_bits-1:0]  rd_data;

  // bank to output.
  logic [mode_bits-1:0] reg_mode;
  logic [num_bits-1:0]  reg_direct;
  logic [num_bits-1:0]  reg_direct2;

  spi_slave u_spi_slave (
    .clk        (clk),
    .reset      (reset),
    .spi_cs_n   (spi_cs_n),
    .spi_sck    (spi_sck),
    .spi_mosi   (spi_mosi),
    .rd_data    (rd_data),
    .spi_miso   (spi_miso),
    .addr_valid (addr_valid),
    .is_read    (is_read),
    .addr       (addr),
    .wr_strobe  (wr_strobe),
    .wr_data    (wr_data)
  );

  spi_reg_bank u_reg_bank (
    .clk         (clk),
    .reset       (reset),
    .addr_valid  (addr_valid),
    .is_read     (is_read),
    .addr        (addr),
    .wr_strobe   (wr_strobe),
    .wr_data     (wr_data),
    .rd_data     (rd_data),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2)
  );

  switch_output #(
    .half_period (half_period)
  ) u_switch_output (
    .clk         (clk),
    .reset       (reset),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2),
    .sw_out      (sw_out)
  );

endmodule

//--- bench/tb_clock.sv
//////////////////////////////
// testbench clock and reset, 4 ns period.
//////////////////////////////
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;            // held for 3 rising edges.
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  end

  always #2 clk = ~clk;      // 250 mhz.

endmodule

//--- bench/tb_sva.sv
//////////////////////////////
// assertions on switch_output, bound in.
//////////////////////////////
`timescale 1ns/1ps

module tb_sva
  import sw_pkg::*;
#(
  parameter int half_period = 50
)
(
  input logic                                   clk,
  input logic                                   reset,
  input logic [mode_bits-1:0]                   reg_mode,
  input logic [num_bits-1:0]                    reg_direct,
  input logic [num_bits-1:0]                    reg_direct2,
  input logic [num_bits-1:0]                    sw_out,
  input logic [$clog2(half_period + 1)-1:0]     alt_counter  // generator count.
);

  int fail_count = 0;

  function automatic logic is_off(input logic [mode_bits-1:0] m);
    return (m == mode_off) || (m == 2'd3);  // code 3 acts as off.
  endfunction

  // two stages from reg_mode to sw_out.
  off_gives_zero: assert property (@(posedge clk) disable iff (reset)
    is_off($past(reg_mode, 2)) |-> sw_out == '0)
  else
  begin
    fail_count++;
    $error("sw_out not zero with switches off");
  end

  alt_word_legal: assert property (@(posedge clk) disable iff (reset)
    ($past(reg_mode, 2) == mode_alternate) |->
      (sw_out == reg_direct || sw_out == reg_direct2 || sw_out == '0))
  else
  begin
    fail_count++;
    $error("alternate sw_out is neither register word nor zero");
  end

  counter_bound: assert property (@(posedge clk) disable iff (reset)
    alt_counter <= half_period)
  else
  begin
    fail_count++;
    $error("alternate counter past half period");
  end

endmodule

bind switch_output tb_sva #(
  .half_period (half_period)
) u_sva (
  .clk         (clk),
  .reset       (reset),
  .reg_mode    (reg_mode),
  .reg_direct  (reg_direct),
  .reg_direct2 (reg_direct2),
  .sw_out      (sw_out),
  .alt_counter (u_alternate.counter)
);

//--- bench/tb_checker.sv
//////////////////////////////
// checker. decodes miso, tracks the register model
// and compares readback and switch words.
//////////////////////////////
`timescale 1ns/1ps

module tb_checker
  import sw_pkg::*;
#(
  parameter int half_period = 50
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 spi_cs_n,
  input  logic                 spi_sck,
  input  logic                 spi_miso,
  input  logic [num_bits-1:0]  sw_out,
  input  logic                 chk_valid,   // entry handed over.
  input  int                   chk_kind,
  input  logic [addr_bits-1:0] chk_addr,
  input  logic [num_bits-1:0]  chk_data,
  input  logic [num_bits-1:0]  chk_exp,
  output logic                 chk_ack,
  output int                   err_count
);

  localparam int k_write  = 0;
  localparam int k_read   = 1;
  localparam int k_wr_sw  = 4;
  localparam int k_wr_alt = 5;

  logic [num_bits-1:0]  rx_shift;   // last 24 miso bits, the readback word.
  logic                 sw_moved;   // sw_out changed inside the current frame.
  logic                 cs_last;
  logic [num_bits-1:0]  sw_last;
  logic [mode_bits-1:0] m_mode;     // model of the writable registers.
  logic [num_bits-1:0]  m_direct2;

  // host samples miso on rising sck.
  always @(posedge spi_sck)
  begin
    if (!spi_cs_n)
      rx_shift <= {rx_shift[num_bits-2:0], spi_miso};
  end

  always @(negedge clk)
  begin
    if (reset)
      sw_moved = 1'b0;
    else if (!spi_cs_n)
    begin
      if (cs_last)
        sw_moved = 1'b0;  // frame start.
      else if (sw_out !== sw_last)
        sw_moved = 1'b1;
    end
    cs_last = spi_cs_n;
    sw_last = sw_out;
  end

  // full frames to writable addresses update the model.
  task update_model;
    if (chk_kind == k_write || chk_kind == k_wr_sw || chk_kind == k_wr_alt)
    begin
      if (chk_addr == addr_mode)
        m_mode = chk_data[mode_bits-1:0];
      else if (chk_addr == addr_direct2)
        m_direct2 = chk_data;
    end
  endtask

  task check_read;
    if (rx_shift !== chk_exp)
    begin
      err_count++;
      $display("ERROR at %0t: read of addr %0h gave %h, expected %h",
               $time, chk_addr, rx_shift, chk_exp);
    end
    if (sw_moved && m_mode != mode_alternate)
    begin
      err_count++;
      $display("ERROR at %0t: sw_out changed during read of addr %0h", $time, chk_addr);
    end
  endtask

  // settle within a few cycles, then hold.
  task check_settle;
    int n;
    n = 0;
    while (sw_out !== chk_exp && n < 12)
    begin
      @(negedge clk);
      n++;
    end
    while (sw_out === chk_exp && n < 32)
    begin
      @(negedge clk);
      n++;
    end
    if (sw_out !== chk_exp)
    begin
      err_count++;
      $display("ERROR at %0t: sw_out is %h, expected steady %h", $time, sw_out, chk_exp);
    end
  endtask

  // first change to direct, then four swaps of half_period + 1.
  task check_alternate;
    logic [num_bits-1:0] prev;
    logic [num_bits-1:0] want;
    int                  gap;
    int                  swap;
    prev = sw_out;
    gap  = 0;
    while (sw_out === prev && gap < 4 * (half_period + 1))
    begin
      @(negedge clk);
      gap++;
    end
    if (sw_out === prev)
    begin
      err_count++;
      $display("alternate mode: sw_out never changed, stuck at %h", prev);
    end
    else
    begin
      if (sw_out !== chk_exp)
      begin
        err_count++;
        $display("ERROR at %0t: first alternate word %h, expected %h", $time, sw_out, chk_exp);
      end
      for (swap = 1; swap <= 4; swap++)
      begin
        want = (swap % 2) ? m_direct2 : chk_exp;
        prev = sw_out;
        gap  = 0;
        do
        begin
          @(negedge clk);
          gap++;
        end
        while (sw_out === prev && gap < 2 * (half_period + 1));
        if (gap != half_period + 1 || sw_out !== want)
        begin
          err_count++;
          $display("ERROR at %0t: swap %0d gave %h after %0d cycles, expected %h after %0d",
                   $time, swap, sw_out, gap, want, half_period + 1);
        end
      end
    end
  endtask

  initial
  begin
    chk_ack   = 1'b0;
    err_count = 0;
    m_mode    = mode_off;
    m_direct2 = '0;
    forever
    begin
      @(negedge clk);
      if (chk_valid && !chk_ack)
      begin
        update_model();
        case (chk_kind)
          k_read:   check_read();
          k_wr_sw:  check_settle();
          k_wr_alt: check_alternate();
          default:  ;  // short and long frames show up in later reads.
        endcase
        chk_ack = 1'b1;
      end
      else if (!chk_valid && chk_ack)
        chk_ack = 1'b0;
    end
  end

endmodule

//--- bench/tb_top.sv
//////////////////////////////
// testbench top. plays the stimulus table as spi frames
// and hands each entry to the checker.
//////////////////////////////
`timescale 1ns/1ps

module tb_top
  import sw_pkg::*;
;

  localparam int half_period = 50;
  localparam int sck_hold    = 6;    // clk cycles per sck level.
  localparam int k_write     = 0;
  localparam int k_read      = 1;
  localparam int k_short     = 2;    // 20 bit frame.
  localparam int k_long      = 3;    // 36 bit frame.
  localparam int k_wr_sw     = 4;    // write, then sw_out settles to exp.
  localparam int k_wr_alt    = 5;    // write, then alternating pattern.
  // setup + 36 bits + tail + settle + checker time.
  localparam int frame_cycles = 2 * sck_hold + 36 * 2 * sck_hold + 60;

  logic                clk;
  logic                reset;
  logic                spi_cs_n;
  logic                spi_sck;
  logic                spi_mosi;
  logic                spi_miso;
  logic [num_bits-1:0] sw_out;
  logic                chk_valid;
  logic                chk_ack;
  int                  chk_kind;
  logic [addr_bits-1:0] chk_addr;
  logic [num_bits-1:0] chk_data;
  logic [num_bits-1:0] chk_exp;
  int                  err_count;
  int                  timeout_cycles;

  // stimulus table.
  int                   t_kind[$];
  logic [addr_bits-1:0] t_addr[$];
  logic [num_bits-1:0]  t_data[$];
  logic [num_bits-1:0]  t_exp[$];

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  sw_ctrl_top #(
    .half_period (half_period)
  ) dut (
    .clk      (clk),
    .reset    (reset),
    .spi_cs_n (spi_cs_n),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .sw_out   (sw_out)
  );

  tb_checker #(
    .half_period (half_period)
  ) u_checker (
    .clk       (clk),
    .reset     (reset),
    .spi_cs_n  (spi_cs_n),
    .spi_sck   (spi_sck),
    .spi_miso  (spi_miso),
    .sw_out    (sw_out),
    .chk_valid (chk_valid),
    .chk_kind  (chk_kind),
    .chk_addr  (chk_addr),
    .chk_data  (chk_data),
    .chk_exp   (chk_exp),
    .chk_ack   (chk_ack),
    .err_count (err_count)
  );

  // n rising edges, then 1 ns into the cycle.
  task wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task add_entry(input int kind, input logic [addr_bits-1:0] addr,
                 input logic [num_bits-1:0] data, input logic [num_bits-1:0] exp);
    t_kind.push_back(kind);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_exp.push_back(exp);
  endtask

  // one frame, msb first, mode 0.
  task send_frame(input logic [7:0] cmd, input logic [num_bits-1:0] data, input int nbits);
    logic [35:0] bits;
    int          i;
    bits = {cmd, data, 4'b1010};  // tail only goes out on long frames.
    wait_cycles(1);
    spi_cs_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_mosi = bits[35 - i];
      wait_cycles(sck_hold);
      spi_sck = 1'b1;
      wait_cycles(sck_hold);
      spi_sck = 1'b0;
    end
    wait_cycles(sck_hold);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    wait_cycles(8);  // write strobe and register update.
  endtask

  // four phase handshake with the checker.
  task hand_over(input int idx);
    chk_kind  = t_kind[idx];
    chk_addr  = t_addr[idx];
    chk_data  = t_data[idx];
    chk_exp   = t_exp[idx];
    chk_valid = 1'b1;
    do
      wait_cycles(1);
    while (!chk_ack);
    chk_valid = 1'b0;
    do
      wait_cycles(1);
    while (chk_ack);
  endtask

  initial
  begin
    int                  seed;
    int                  idx;
    int                  nbits;
    int                  sva_fails;
    logic [num_bits-1:0] d1;
    logic [num_bits-1:0] d2;
    logic [num_bits-1:0] d3;
    spi_cs_n       = 1'b1;
    spi_sck        = 1'b0;
    spi_mosi       = 1'b0;
    chk_valid      = 1'b0;
    chk_kind       = k_write;
    chk_addr       = '0;
    chk_data       = '0;
    chk_exp        = '0;
    timeout_cycles = 0;
    seed = 58678;
    void'($urandom(seed));
    d1 = num_bits'($urandom());
    do
      d2 = num_bits'($urandom());
    while (d2 == '0);
    do
      d3 = num_bits'($urandom());
    while (d3 == '0 || d3 == d2);  // alternate needs two distinct words.

    add_entry(k_write, addr_direct, d1, '0);
    add_entry(k_write, addr_direct2, d2, '0);
    add_entry(k_read, addr_direct, '0, d1);
    add_entry(k_read, addr_direct2, '0, d2);
    add_entry(k_write, addr_id, 24'h123456, '0);   // read only.
    add_entry(k_read, addr_id, '0, id_value);
    add_entry(k_short, addr_direct, 24'h0F0F0F, '0);
    add_entry(k_read, addr_direct, '0, d1);
    add_entry(k_long, addr_direct2, ~d2, '0);
    add_entry(k_read, addr_direct2, '0, d2);
    add_entry(k_write, addr_direct, d3, '0);
    add_entry(k_wr_sw, addr_mode, 24'(mode_direct), d3);
    add_entry(k_read, 7'h55, '0, '0);              // unused address.
    add_entry(k_read, addr_mode, '0, 24'(mode_direct));
    add_entry(k_wr_sw, addr_mode, 24'd3, '0);      // invalid code.
    add_entry(k_read, addr_mode, '0, 24'd3);
    add_entry(k_wr_sw, addr_mode, 24'(mode_off), '0);
    add_entry(k_wr_alt, addr_mode, 24'(mode_alternate), d3);
    add_entry(k_wr_sw, addr_mode, 24'(mode_off), '0);
    add_entry(k_read, addr_direct, '0, d3);
    add_entry(k_read, addr_direct2, '0, d2);

    timeout_cycles = 2 * (t_kind.size() * frame_cycles + 6 * (half_period + 1));
    @(negedge reset);
    wait_cycles(4);
    for (idx = 0; idx < t_kind.size(); idx++)
    begin
      case (t_kind[idx])
        k_short: nbits = 20;
        k_long:  nbits = 36;
        default: nbits = frame_bits;
      endcase
      send_frame({t_kind[idx] == k_read, t_addr[idx]}, t_data[idx], nbits);
      hand_over(idx);
    end
    wait_cycles(4);
    sva_fails = dut.u_switch_output.u_sva.fail_count;
    $display("checker errors: %0d, assertion failures: %0d", err_count, sva_fails);
    if (err_count == 0 && sva_fails == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog limit scales with the table length.
  initial
  begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: table not finished after %0d cycles, run stopped", timeout_cycles);
    $display("checker errors: %0d", err_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb.f
common/sw_pkg.sv
spi/spi_slave.sv
spi/spi_reg_bank.sv
hw/pattern_alternate.sv
hw/switch_output.sv
hw/sw_ctrl_top.sv
bench/tb_clock.sv
bench/tb_sva.sv
bench/tb_checker.sv
bench/tb_top.sv
